// ==== design/freq_counter_pkg.sv ====
// ======================================================================
// frequency counter package
// widths, gate length, scan timing, the shared BCD word and the
// seven-segment decode
// ======================================================================
`default_nettype none

package freq_counter_pkg;

	// edge count per window
	localparam int count_width = 20;
	// gate window length in clocks
	localparam int gate_cycles = 2000;
	localparam int gate_width = $clog2(gate_cycles);
	localparam int bcd_digits = 6;
	localparam int bcd_width = 4 * bcd_digits;
	localparam int digit_width = $clog2(bcd_digits);
	// one shift per count bit
	localparam int shift_width = $clog2(count_width);
	// clocks each digit stays lit
	localparam int scan_dwell = 8;
	localparam int dwell_width = $clog2(scan_dwell);

	// digit 0 is the least significant nibble
	typedef union packed {
		logic [bcd_width-1:0] flat;
		logic [bcd_digits-1:0][3:0] digit;
	} bcd_word_t;

	// segments dp,g,f,e,d,c,b,a, active high, dp never lit
	function automatic logic [7:0] seg_code(input logic [3:0] value);
		case (value)
			4'h0: seg_code = 8'h3f;
			4'h1: seg_code = 8'h06;
			4'h2: seg_code = 8'h5b;
			4'h3: seg_code = 8'h4f;
			4'h4: seg_code = 8'h66;
			4'h5: seg_code = 8'h6d;
			4'h6: seg_code = 8'h7d;
			4'h7: seg_code = 8'h07;
			4'h8: seg_code = 8'h7f;
			4'h9: seg_code = 8'h6f;
			4'ha: seg_code = 8'h77;
			4'hb: seg_code = 8'h7c;
			4'hc: seg_code = 8'h39;
			4'hd: seg_code = 8'h5e;
			4'he: seg_code = 8'h79;
			default: seg_code = 8'h71;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== design/gate_timer.sv ====
// ======================================================================
// gate timer
// free-running window counter, one-cycle gate_end at each window end
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module gate_timer
	import freq_counter_pkg::*;
(
	input wire clock,
	input wire reset,
	output logic gate_end
);

	// position inside the current window
	logic [gate_width-1:0] gate_count;
	logic last_cycle;

	// last clock of the window
	assign last_cycle = (gate_count == gate_width'(gate_cycles - 1));

	// modulo gate_cycles
	always_ff @(posedge clock) begin
		if (reset) begin
			gate_count <= '0;
		end else if (last_cycle) begin
			gate_count <= '0;
		end else begin
			gate_count <= gate_count + 1'b1;
		end
	end

	// window ends on the wrap cycle
	// first pulse lands gate_cycles clocks after reset is released
	assign gate_end = last_cycle;

	// the accumulator hands over once per window, a double pulse would
	// hand over an empty total
	property p_single_pulse;
		@(posedge clock) disable iff (reset)
		gate_end |=> !gate_end;
	endproperty

	a_single_pulse: assert property (p_single_pulse)
		else $error("gate_end high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== design/edge_accumulator.sv ====
// ======================================================================
// edge accumulator
// synchronizes freq_in, counts its rising edges per gate window and
// hands the total over at each window end
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module edge_accumulator
	import freq_counter_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire freq_in,
	input wire gate_end,
	output logic [count_width-1:0] count,
	output logic count_valid
);

	// two-flop synchronizer
	logic sync_meta;
	logic sync_stable;
	// previous synchronized level
	logic edge_reg;
	// registered rising edge, one cycle wide
	logic rise;
	// running total for the open window
	logic [count_width-1:0] total;

	always_ff @(posedge clock) begin
		if (reset) begin
			sync_meta <= 1'b0;
			sync_stable <= 1'b0;
			edge_reg <= 1'b0;
			rise <= 1'b0;
		end else begin
			sync_meta <= freq_in;
			sync_stable <= sync_meta;
			edge_reg <= sync_stable;
			// low to high on the stable level
			rise <= sync_stable & ~edge_reg;
		end
	end

	// accumulate, clear at window end
	// an edge in the gate_end cycle still belongs to the closing window
	always_ff @(posedge clock) begin
		if (reset) begin
			total <= '0;
			count_valid <= 1'b0;
		end else begin
			count_valid <= gate_end;
			if (gate_end) begin
				total <= '0;
			end else if (rise) begin
				total <= total + 1'b1;
			end
		end
	end

	// handed-over total, like previous_accumulator
	always_ff @(posedge clock) begin
		if (gate_end) begin
			count <= total + count_width'(rise);
		end
	end

	// at most one edge per clock, so a window can never hold more
	// edges than it has clocks
	property p_total_bound;
		@(posedge clock) disable iff (reset)
		total <= count_width'(gate_cycles);
	endproperty

	a_total_bound: assert property (p_total_bound)
		else $error("edge total exceeds window length");

endmodule

`default_nettype wire

// ==== design/bin_to_bcd.sv ====
// ======================================================================
// binary to BCD converter
// sequential double dabble, one count bit per clock, six BCD digits
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd
	import freq_counter_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire [count_width-1:0] count,
	input wire count_valid,
	output bcd_word_t bcd,
	output logic bcd_valid
);

	// conversion in flight
	logic busy;
	// shifts done so far
	logic [shift_width-1:0] shift_count;
	logic last_shift;
	// binary bits still to be shifted in, msb first
	logic [count_width-1:0] bin_sr;
	// partial BCD result
	bcd_word_t bcd_sr;
	// partial result after the add-3 step
	bcd_word_t adjusted;
	// partial result after this cycle's shift
	logic [bcd_width-1:0] shifted;

	// add 3 to every digit of 5 or more before the shift
	always_comb begin
		adjusted = bcd_sr;
		for (int i = 0; i < bcd_digits; i++) begin
			if (bcd_sr.digit[i] >= 4'd5) begin
				adjusted.digit[i] = bcd_sr.digit[i] + 4'd3;
			end
		end
	end

	// next binary msb enters at the bottom
	assign shifted = {adjusted.flat[bcd_width-2:0], bin_sr[count_width-1]};
	assign last_shift = (shift_count == shift_width'(count_width - 1));

	// control
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			shift_count <= '0;
			bcd_valid <= 1'b0;
		end else begin
			bcd_valid <= 1'b0;
			if (count_valid) begin
				busy <= 1'b1;
				shift_count <= '0;
			end else if (busy) begin
				shift_count <= shift_count + 1'b1;
				if (last_shift) begin
					busy <= 1'b0;
					bcd_valid <= 1'b1;
				end
			end
		end
	end

	// shift registers, loaded on count_valid
	always_ff @(posedge clock) begin
		if (count_valid) begin
			bin_sr <= count;
			bcd_sr.flat <= '0;
		end else if (busy) begin
			bin_sr <= {bin_sr[count_width-2:0], 1'b0};
			bcd_sr.flat <= shifted;
		end
	end

	// result held until the next conversion finishes
	always_ff @(posedge clock) begin
		if (reset) begin
			bcd.flat <= '0;
		end else if (busy && last_shift) begin
			bcd.flat <= shifted;
		end
	end

	// windows are far longer than a conversion, so the gate never
	// hands over a count while one is running
	property p_no_overlap;
		@(posedge clock) disable iff (reset)
		count_valid |-> !busy;
	endproperty

	a_no_overlap: assert property (p_no_overlap)
		else $error("count_valid while conversion busy");

endmodule

`default_nettype wire

// ==== design/seven_seg_scanner.sv ====
// ======================================================================
// seven-segment scanner
// buffers the BCD word, scans six anodes and decodes the lit digit
// with leading-zero blanking
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module seven_seg_scanner
	import freq_counter_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire bcd_word_t bcd,
	input wire bcd_valid,
	output logic [7:0] segment,
	output logic [bcd_digits-1:0] anode
);

	// digits on the display, like buffered_bcd
	bcd_word_t display;
	// clocks spent on the current digit
	logic [dwell_width-1:0] dwell_count;
	// digit being lit
	logic [digit_width-1:0] digit_index;
	// digit i and everything above it are zero
	logic [bcd_digits-1:0] upper_zero;
	// all incoming digits are decimal
	logic bcd_in_range;

	// update only when a new result arrives
	always_ff @(posedge clock) begin
		if (reset) begin
			display.flat <= '0;
		end else if (bcd_valid) begin
			display <= bcd;
		end
	end

	// dwell then step to the next digit, wrap after the top one
	always_ff @(posedge clock) begin
		if (reset) begin
			dwell_count <= '0;
			digit_index <= '0;
		end else if (dwell_count == dwell_width'(scan_dwell - 1)) begin
			dwell_count <= '0;
			if (digit_index == digit_width'(bcd_digits - 1)) begin
				digit_index <= '0;
			end else begin
				digit_index <= digit_index + 1'b1;
			end
		end else begin
			dwell_count <= dwell_count + 1'b1;
		end
	end

	// one-hot anode
	assign anode = bcd_digits'(1) << digit_index;

	// leading-zero map, built from the top digit down
	always_comb begin
		upper_zero[bcd_digits-1] = (display.digit[bcd_digits-1] == 4'd0);
		for (int i = bcd_digits - 2; i >= 0; i--) begin
			upper_zero[i] = (display.digit[i] == 4'd0) && upper_zero[i+1];
		end
	end

	// digit 0 always shows, even for a zero count
	always_comb begin
		if (digit_index != '0 && upper_zero[digit_index]) begin
			segment = 8'h00;
		end else begin
			segment = seg_code(display.digit[digit_index]);
		end
	end

	always_comb begin
		bcd_in_range = 1'b1;
		for (int i = 0; i < bcd_digits; i++) begin
			if (bcd.digit[i] > 4'd9) begin
				bcd_in_range = 1'b0;
			end
		end
	end

	// the converter only produces decimal digits
	property p_decimal_digits;
		@(posedge clock) disable iff (reset)
		bcd_valid |-> bcd_in_range;
	endproperty

	a_decimal_digits: assert property (p_decimal_digits)
		else $error("non-decimal digit in BCD result");

endmodule

`default_nettype wire

// ==== design/freq_counter_top.sv ====
// ======================================================================
// frequency counter top
// gate timer, edge accumulator, BCD converter and display scanner
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module freq_counter_top
	import freq_counter_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire freq_in,
	output bcd_word_t bcd,
	output logic bcd_valid,
	output logic [7:0] segment,
	output logic [bcd_digits-1:0] anode
);

	// window end pulse
	logic gate_end;
	// finished window total and its strobe
	logic [count_width-1:0] count;
	logic count_valid;

	// measurement time base
	gate_timer u_gate_timer (
		.clock(clock),
		.reset(reset),
		.gate_end(gate_end)
	);

	// edges of freq_in per window
	edge_accumulator u_edge_accumulator (
		.clock(clock),
		.reset(reset),
		.freq_in(freq_in),
		.gate_end(gate_end),
		.count(count),
		.count_valid(count_valid)
	);

	// 21 clocks from count_valid to bcd_valid
	bin_to_bcd u_bin_to_bcd (
		.clock(clock),
		.reset(reset),
		.count(count),
		.count_valid(count_valid),
		.bcd(bcd),
		.bcd_valid(bcd_valid)
	);

	seven_seg_scanner u_seven_seg_scanner (
		.clock(clock),
		.reset(reset),
		.bcd(bcd),
		.bcd_valid(bcd_valid),
		.segment(segment),
		.anode(anode)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// ======================================================================
// testbench clock generator
// free-running clock with a 4 ns period
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock
);

	// half of the 4 ns period
	localparam int half_period_ns = 2;

	initial begin
		clock = 1'b0;
		forever begin
			#(half_period_ns);
			clock = ~clock;
		end
	end

endmodule

`default_nettype wire

// ==== tests/freq_counter_tb.sv ====
// ======================================================================
// frequency counter testbench
// random square waves per gate window, checked against a cycle model
// of the edge count, the BCD result, the anode scan and the segments
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module freq_counter_tb
	import freq_counter_pkg::*;
();

	localparam int unsigned random_seed = 32'h00b4_bcd5;
	localparam int reset_cycles = 16;
	// results checked before the run ends
	localparam int windows_to_check = 10;
	// model covers a couple of spare windows
	localparam int max_windows = 12;
	// bcd_valid 22 clocks after gate_end in cycle gate_cycles
	localparam int first_result_cycle = gate_cycles + 22;
	localparam int timeout_cycles = max_windows * gate_cycles + 200;
	// drive edge, two sync flops and the edge register
	localparam int edge_delay = 4;
	localparam int max_half_period = 40;

	logic clock;
	logic reset;
	logic freq_in;
	bcd_word_t bcd;
	logic bcd_valid;
	logic [7:0] segment;
	logic [bcd_digits-1:0] anode;

	// clock periods counted from 1 after reset is released
	int cycle = 0;
	int windows_done = 0;
	// expected edges per window, index 1 is the first window
	int model_count [0:max_windows];
	// digits the display should hold
	int shown_digit [0:bcd_digits-1];

	// stimulus state
	logic freq_level = 1'b0;
	logic hold_level = 1'b0;
	int half_period = 1;
	int phase_count = 0;

	tb_clock_gen clock_source (
		.clock(clock)
	);

	freq_counter_top UUT (
		.clock(clock),
		.reset(reset),
		.freq_in(freq_in),
		.bcd(bcd),
		.bcd_valid(bcd_valid),
		.segment(segment),
		.anode(anode)
	);

	// decimal digit of a value at a position counted from the units
	function automatic int decimal_digit(input int value, input int position);
		int rest;
		rest = value;
		for (int i = 0; i < position; i++) begin
			rest = rest / 10;
		end
		return rest % 10;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("Some tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// toggle rate for a new window
	task automatic choose_window_rate(input int window);
		int unsigned mode;
		mode = $urandom % 6;
		phase_count = 0;
		hold_level = 1'b0;
		if (window == 2) begin
			// always one quiet window
			hold_level = 1'b1;
		end else if (window == 4) begin
			// always one window at the top rate
			half_period = 1;
		end else if (mode == 0) begin
			hold_level = 1'b1;
		end else if (mode == 1) begin
			half_period = 1 + int'($urandom % 3);
		end else begin
			half_period = 1 + int'($urandom % max_half_period);
		end
	endtask

	// compare one converted result and take it as the displayed value
	task automatic check_window_result();
		int expected;
		windows_done = windows_done + 1;
		expected = model_count[windows_done];
		for (int i = 0; i < bcd_digits; i++) begin
			check_value(32'(bcd.digit[i]), 32'(decimal_digit(expected, i)),
				$sformatf("window %0d digit %0d", windows_done, i));
			shown_digit[i] = decimal_digit(expected, i);
		end
	endtask

	// reset and then one stimulus step per rising edge
	initial begin
		int rise_cycle;
		int rise_window;
		void'($urandom(random_seed));
		reset = 1'b1;
		freq_in = 1'b0;
		for (int k = 0; k <= max_windows; k++) begin
			model_count[k] = 0;
		end
		for (int i = 0; i < bcd_digits; i++) begin
			shown_digit[i] = 0;
		end
		repeat (reset_cycles) begin
			@(posedge clock);
		end
		reset <= 1'b0;
		forever begin
			@(posedge clock);
			// rate changes early so each rise lands in the window it was drawn for
			if (cycle == 1 || (cycle + edge_delay - 1) % gate_cycles == 0) begin
				choose_window_rate((cycle + edge_delay - 1) / gate_cycles + 1);
			end
			if (!hold_level) begin
				phase_count = phase_count + 1;
				if (phase_count >= half_period) begin
					phase_count = 0;
					if (!freq_level) begin
						// counted in the window holding the edge pulse
						rise_cycle = cycle + edge_delay;
						rise_window = (rise_cycle - 1) / gate_cycles + 1;
						if (rise_window <= max_windows) begin
							model_count[rise_window] = model_count[rise_window] + 1;
						end
					end
					freq_level = ~freq_level;
					freq_in <= freq_level;
				end
			end
		end
	end

	// checks on the falling edge where outputs are settled
	always @(negedge clock) begin
		int scan_index;
		logic blank;
		logic expected_valid;
		logic [7:0] expected_segment;
		if (!reset) begin
			cycle = cycle + 1;
			if (cycle >= timeout_cycles) begin
				$display("run timed out after %0d cycles before all results arrived", cycle);
				$display("Some tests failed");
				$fatal(1, "timeout");
			end else begin
				// nothing converted yet
				if (cycle == 1) begin
					check_value(32'(bcd.flat), 32'd0, "bcd after reset");
				end
				// one result per window at a fixed latency
				expected_valid = (cycle >= first_result_cycle)
					&& ((cycle - first_result_cycle) % gate_cycles == 0);
				check_value(32'(bcd_valid), 32'(expected_valid), "bcd_valid");
				// one-hot scan with scan_dwell clocks per digit
				scan_index = ((cycle - 1) / scan_dwell) % bcd_digits;
				check_value(32'(anode), 32'(1) << scan_index, "anode");
				// leading zeros dark except digit 0
				blank = (scan_index != 0);
				for (int i = scan_index; i < bcd_digits; i++) begin
					if (shown_digit[i] != 0) begin
						blank = 1'b0;
					end
				end
				if (blank) begin
					expected_segment = 8'h00;
				end else begin
					expected_segment = seg_code(4'(shown_digit[scan_index]));
				end
				check_value(32'(segment), 32'(expected_segment),
					$sformatf("segment of digit %0d", scan_index));
				// display takes the new digits from the next cycle on
				if (bcd_valid) begin
					check_window_result();
					if (windows_done == windows_to_check) begin
						$display("All tests passed");
						$finish;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== freq_counter.f ====
design/freq_counter_pkg.sv
design/gate_timer.sv
design/edge_accumulator.sv
design/bin_to_bcd.sv
design/seven_seg_scanner.sv
design/freq_counter_top.sv
tests/tb_clock_gen.sv
tests/freq_counter_tb.sv

// ==== Makefile ====
# Verilator build and run of the frequency counter testbench
# any variable can be overridden, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP ?= freq_counter_tb
FILELIST ?= freq_counter.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

# every source named in the file list, so an edit triggers a rebuild
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: build

build: $(SIM)

# simulator binary for a given top module
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
